// ==== Makefile ====
# Verilator build and run of the DMA controller testbench

TOP      ?= tb_dma_ctrl_top
FILELIST ?= dma_ctrl_top.f
VFLAGS   ?= --binary --timing --assert
BUILD    ?= obj_dir
PASS_MSG ?= All tests passed

SIM     := $(BUILD)/V$(TOP)
SOURCES := $(wildcard design/*.sv design/*.svh tests/*.sv)

.PHONY: all run lint clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	verilator $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)

// ==== design/dma_cmd_writer.sv ====
// one chunk at a time; the engine's writer interrupt must stay high until the clear write lands
`timescale 1ns/1ns
`default_nettype none

`include "dma_ctrl_settings.svh"

module dma_cmd_writer (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                chunk_start,
    input  wire dma_ctrl_pkg::data_t chunk_btt,
    input  wire dma_ctrl_pkg::addr_t chunk_src,
    input  wire dma_ctrl_pkg::addr_t chunk_dst,
    input  wire logic                dma_writer_interrupt,
    input  wire logic                wr_done,
    output logic                     chunk_done,
    output logic                     wr_req,
    output dma_ctrl_pkg::reg_addr_t  wr_addr,
    output dma_ctrl_pkg::data_t      wr_data
);
    import dma_ctrl_pkg::*;

    // reader and writer bits for mask, start and clear
    localparam data_t BOTH_CH = 32'd3;

    cmd_state_t state;
    data_t      btt_q;
    addr_t      src_q;
    addr_t      dst_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= C_IDLE;
            wr_req     <= 1'b0;
            chunk_done <= 1'b0;
        end else begin
            wr_req     <= 1'b0;
            chunk_done <= 1'b0;
            case (state)
                C_IDLE: if (chunk_start) begin
                    wr_req  <= 1'b1;
                    wr_addr <= `REG_INTR_MASK;
                    wr_data <= BOTH_CH;
                    state   <= C_MASK;
                end
                C_MASK: if (wr_done) begin
                    wr_req  <= 1'b1;
                    wr_addr <= `REG_BTT;
                    wr_data <= btt_q;
                    state   <= C_BTT;
                end
                C_BTT: if (wr_done) begin
                    wr_req  <= 1'b1;
                    wr_addr <= `REG_READER_ADDR;
                    wr_data <= data_t'(src_q);
                    state   <= C_RADDR;
                end
                C_RADDR: if (wr_done) begin
                    wr_req  <= 1'b1;
                    wr_addr <= `REG_WRITER_ADDR;
                    wr_data <= data_t'(dst_q);
                    state   <= C_WADDR;
                end
                C_WADDR: if (wr_done) begin
                    // kick both reader and writer
                    wr_req  <= 1'b1;
                    wr_addr <= `REG_CONTROL;
                    wr_data <= BOTH_CH;
                    state   <= C_CTRL;
                end
                C_CTRL: if (wr_done) begin
                    state <= C_WAIT_INTR;
                end
                C_WAIT_INTR: if (dma_writer_interrupt) begin
                    wr_req  <= 1'b1;
                    wr_addr <= `REG_INTR_STATUS;
                    wr_data <= BOTH_CH;
                    state   <= C_CLEAR;
                end
                C_CLEAR: if (wr_done) begin
                    chunk_done <= 1'b1;
                    state      <= C_IDLE;
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    // chunk parameters kept until the address writes are sent
    always_ff @(posedge clk) begin
        if (state == C_IDLE && chunk_start) begin
            btt_q <= chunk_btt;
            src_q <= chunk_src;
            dst_q <= chunk_dst;
        end
    end

    a_start_when_idle: assert property (@(posedge clk) disable iff (rst)
        chunk_start |-> state == C_IDLE);

endmodule

`default_nettype wire

// ==== design/dma_ctrl_pkg.sv ====
// types shared by the DMA controller; widths come from dma_ctrl_settings.svh
`default_nettype none

`include "dma_ctrl_settings.svh"

package dma_ctrl_pkg;

    typedef logic [`DMA_ADDR_W-1:0]     addr_t;
    typedef logic [`DMA_DATA_W-1:0]     data_t;
    typedef logic [`DMA_REG_ADDR_W-1:0] reg_addr_t;
    // chunk counts, limits and steps
    typedef logic [`DMA_CNT_W-1:0]      cnt_t;

    // job phases run in declaration order after P_IDLE
    typedef enum logic [2:0] {
        P_IDLE,
        P_BRING_A,
        P_BRING_B,
        P_BRING_C,
        P_SYNC,
        P_SEND_C
    } phase_t;

    // each write state names the register write in flight
    typedef enum logic [2:0] {
        C_IDLE,
        C_MASK,
        C_BTT,
        C_RADDR,
        C_WADDR,
        C_CTRL,
        C_WAIT_INTR,
        C_CLEAR
    } cmd_state_t;

    typedef enum logic [1:0] {
        W_IDLE,
        W_SEND,
        W_RESP
    } wr_state_t;

endpackage

`default_nettype wire

// ==== design/dma_ctrl_settings.svh ====
// widths, register map and SRAM windows of the DMA engine; offsets assume a 6-bit register space
`ifndef DMA_CTRL_SETTINGS_SVH
`define DMA_CTRL_SETTINGS_SVH

// bus and counter widths
`define DMA_ADDR_W      32
`define DMA_DATA_W      32
`define DMA_REG_ADDR_W  6
`define DMA_CNT_W       16

// DMA engine register offsets
`define REG_CONTROL     6'h00
`define REG_INTR_MASK   6'h04
`define REG_INTR_STATUS 6'h0C
`define REG_READER_ADDR 6'h10
`define REG_WRITER_ADDR 6'h20
`define REG_BTT         6'h30

// element sizes in bytes
`define A_BYTES         1
`define B_BYTES         2
`define C_BYTES         4

// accelerator-side SRAM windows
`define SRAMA_BASE      32'h0001_0000
`define SRAMB_BASE      32'h0002_0000
`define SRAMC_BASE      32'h0003_0000

`endif

// ==== design/dma_ctrl_top.sv ====
// single-tile DMA controller; start is ignored while busy, configuration held stable while busy
`timescale 1ns/1ns
`default_nettype none

module dma_ctrl_top (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                start,
    input  wire dma_ctrl_pkg::cnt_t  a_ett,
    input  wire dma_ctrl_pkg::cnt_t  a_y_lim,
    input  wire dma_ctrl_pkg::cnt_t  a_y_step,
    input  wire dma_ctrl_pkg::cnt_t  a_z_lim,
    input  wire dma_ctrl_pkg::cnt_t  a_z_step,
    input  wire dma_ctrl_pkg::cnt_t  b_ett,
    input  wire dma_ctrl_pkg::cnt_t  b_y_lim,
    input  wire dma_ctrl_pkg::cnt_t  b_y_step,
    input  wire dma_ctrl_pkg::cnt_t  c_ett,
    input  wire dma_ctrl_pkg::cnt_t  c_y_lim,
    input  wire dma_ctrl_pkg::cnt_t  c_y_step,
    input  wire dma_ctrl_pkg::cnt_t  c_z_lim,
    input  wire dma_ctrl_pkg::cnt_t  c_z_step,
    input  wire dma_ctrl_pkg::addr_t a_dram_base,
    input  wire dma_ctrl_pkg::addr_t b_dram_base,
    input  wire dma_ctrl_pkg::addr_t c_dram_base,
    input  wire logic                sauria_sync,
    input  wire logic                dma_writer_interrupt,
    input  wire logic                awready,
    input  wire logic                wready,
    input  wire logic                bvalid,
    output logic                     awvalid,
    output dma_ctrl_pkg::reg_addr_t  awaddr,
    output logic                     wvalid,
    output dma_ctrl_pkg::data_t      wdata,
    output logic                     bready,
    output logic                     dma_sync,
    output logic                     busy,
    output logic                     done
);
    import dma_ctrl_pkg::*;

    // sequencer to command writer
    logic      chunk_start;
    data_t     chunk_btt;
    addr_t     chunk_src;
    addr_t     chunk_dst;
    logic      chunk_done;

    // command writer to write master
    logic      wr_req;
    reg_addr_t wr_addr;
    data_t     wr_data;
    logic      wr_done;

    dma_phase_sequencer u_seq (
        .clk(clk), .rst(rst), .start(start),
        .a_ett(a_ett), .a_y_lim(a_y_lim), .a_y_step(a_y_step),
        .a_z_lim(a_z_lim), .a_z_step(a_z_step),
        .b_ett(b_ett), .b_y_lim(b_y_lim), .b_y_step(b_y_step),
        .c_ett(c_ett), .c_y_lim(c_y_lim), .c_y_step(c_y_step),
        .c_z_lim(c_z_lim), .c_z_step(c_z_step),
        .a_dram_base(a_dram_base), .b_dram_base(b_dram_base), .c_dram_base(c_dram_base),
        .sauria_sync(sauria_sync), .chunk_done(chunk_done),
        .chunk_start(chunk_start), .chunk_btt(chunk_btt),
        .chunk_src(chunk_src), .chunk_dst(chunk_dst),
        .dma_sync(dma_sync), .busy(busy), .done(done)
    );

    dma_cmd_writer u_cmd (
        .clk(clk), .rst(rst),
        .chunk_start(chunk_start), .chunk_btt(chunk_btt),
        .chunk_src(chunk_src), .chunk_dst(chunk_dst),
        .dma_writer_interrupt(dma_writer_interrupt), .wr_done(wr_done),
        .chunk_done(chunk_done),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    dma_reg_write_master u_wr (
        .clk(clk), .rst(rst),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
        .awready(awready), .wready(wready), .bvalid(bvalid),
        .wr_done(wr_done),
        .awvalid(awvalid), .awaddr(awaddr),
        .wvalid(wvalid), .wdata(wdata), .bready(bready)
    );

endmodule

`default_nettype wire

// ==== design/dma_phase_sequencer.sv ====
// configuration must stay stable while busy; address products wrap at 32 bits
`timescale 1ns/1ns
`default_nettype none

`include "dma_ctrl_settings.svh"

module dma_phase_sequencer (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                start,
    input  wire dma_ctrl_pkg::cnt_t  a_ett,
    input  wire dma_ctrl_pkg::cnt_t  a_y_lim,
    input  wire dma_ctrl_pkg::cnt_t  a_y_step,
    input  wire dma_ctrl_pkg::cnt_t  a_z_lim,
    input  wire dma_ctrl_pkg::cnt_t  a_z_step,
    input  wire dma_ctrl_pkg::cnt_t  b_ett,
    input  wire dma_ctrl_pkg::cnt_t  b_y_lim,
    input  wire dma_ctrl_pkg::cnt_t  b_y_step,
    input  wire dma_ctrl_pkg::cnt_t  c_ett,
    input  wire dma_ctrl_pkg::cnt_t  c_y_lim,
    input  wire dma_ctrl_pkg::cnt_t  c_y_step,
    input  wire dma_ctrl_pkg::cnt_t  c_z_lim,
    input  wire dma_ctrl_pkg::cnt_t  c_z_step,
    input  wire dma_ctrl_pkg::addr_t a_dram_base,
    input  wire dma_ctrl_pkg::addr_t b_dram_base,
    input  wire dma_ctrl_pkg::addr_t c_dram_base,
    input  wire logic                sauria_sync,
    input  wire logic                chunk_done,
    output logic                     chunk_start,
    output dma_ctrl_pkg::data_t      chunk_btt,
    output dma_ctrl_pkg::addr_t      chunk_src,
    output dma_ctrl_pkg::addr_t      chunk_dst,
    output logic                     dma_sync,
    output logic                     busy,
    output logic                     done
);
    import dma_ctrl_pkg::*;

    phase_t phase;
    cnt_t   y;
    cnt_t   z;
    // running byte offset inside the SRAM window
    addr_t  loc_off;

    cnt_t   ett;
    cnt_t   lim_y;
    cnt_t   step_y;
    cnt_t   lim_z;
    cnt_t   step_z;
    addr_t  dram_base;
    addr_t  sram_base;
    addr_t  elem;
    addr_t  btt_bytes;
    addr_t  dram_addr;
    addr_t  loc_addr;

    // buffer selection per phase with y only for buffer B
    always_comb begin
        ett = c_ett;
        lim_y = c_y_lim;
        step_y = c_y_step;
        lim_z = c_z_lim;
        step_z = c_z_step;
        dram_base = c_dram_base;
        sram_base = `SRAMC_BASE;
        elem = addr_t'(`C_BYTES);
        if (phase == P_BRING_A) begin
            ett = a_ett;
            lim_y = a_y_lim;
            step_y = a_y_step;
            lim_z = a_z_lim;
            step_z = a_z_step;
            dram_base = a_dram_base;
            sram_base = `SRAMA_BASE;
            elem = addr_t'(`A_BYTES);
        end else if (phase == P_BRING_B) begin
            ett = b_ett;
            lim_y = b_y_lim;
            step_y = b_y_step;
            lim_z = '0;
            step_z = '0;
            dram_base = b_dram_base;
            sram_base = `SRAMB_BASE;
            elem = addr_t'(`B_BYTES);
        end
    end

    assign btt_bytes = addr_t'(ett) * elem;
    assign dram_addr = dram_base
                     + (addr_t'(y) * addr_t'(step_y) + addr_t'(z) * addr_t'(step_z)) * elem;
    assign loc_addr  = sram_base + loc_off;

    assign chunk_btt = data_t'(btt_bytes);
    // send C reads the SRAM and writes DRAM
    assign chunk_src = (phase == P_SEND_C) ? loc_addr : dram_addr;
    assign chunk_dst = (phase == P_SEND_C) ? dram_addr : loc_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase       <= P_IDLE;
            chunk_start <= 1'b0;
            dma_sync    <= 1'b0;
            busy        <= 1'b0;
            done        <= 1'b0;
        end else begin
            chunk_start <= 1'b0;
            done        <= 1'b0;
            case (phase)
                P_IDLE: if (start) begin
                    busy        <= 1'b1;
                    phase       <= P_BRING_A;
                    chunk_start <= 1'b1;
                end
                P_SYNC: if (sauria_sync) begin
                    dma_sync    <= 1'b0;
                    phase       <= P_SEND_C;
                    chunk_start <= 1'b1;
                end
                default: if (chunk_done) begin
                    if (y == lim_y && z == lim_z) begin
                        // last chunk of the phase
                        case (phase)
                            P_BRING_A: phase <= P_BRING_B;
                            P_BRING_B: phase <= P_BRING_C;
                            P_BRING_C: begin
                                phase    <= P_SYNC;
                                dma_sync <= 1'b1;
                            end
                            default: begin
                                phase <= P_IDLE;
                                busy  <= 1'b0;
                                done  <= 1'b1;
                            end
                        endcase
                        chunk_start <= (phase != P_BRING_C) && (phase != P_SEND_C);
                    end else begin
                        chunk_start <= 1'b1;
                    end
                end
            endcase
        end
    end

    // grid position and SRAM offset
    always_ff @(posedge clk) begin
        if (rst || phase == P_IDLE || phase == P_SYNC) begin
            y       <= '0;
            z       <= '0;
            loc_off <= '0;
        end else if (chunk_done) begin
            loc_off <= loc_off + btt_bytes;
            if (y != lim_y) begin
                y <= y + 1'b1;
            end else begin
                y <= '0;
                if (z != lim_z) begin
                    z <= z + 1'b1;
                end else begin
                    z       <= '0;
                    loc_off <= '0;
                end
            end
        end
    end

    a_no_start_outside_walk: assert property (@(posedge clk) disable iff (rst)
        chunk_start |-> !(phase inside {P_IDLE, P_SYNC}));

endmodule

`default_nettype wire

// ==== design/dma_reg_write_master.sv ====
// one register write at a time; a wr_req before the previous wr_done is a protocol error
`timescale 1ns/1ns
`default_nettype none

`include "dma_ctrl_settings.svh"

module dma_reg_write_master (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   wr_req,
    input  wire dma_ctrl_pkg::reg_addr_t wr_addr,
    input  wire dma_ctrl_pkg::data_t    wr_data,
    input  wire logic                   awready,
    input  wire logic                   wready,
    input  wire logic                   bvalid,
    output logic                        wr_done,
    output logic                        awvalid,
    output dma_ctrl_pkg::reg_addr_t     awaddr,
    output logic                        wvalid,
    output dma_ctrl_pkg::data_t         wdata,
    output logic                        bready
);
    import dma_ctrl_pkg::*;

    wr_state_t state;
    // a channel counts as finished once idle or accepted in this cycle
    logic      aw_ok;
    logic      w_ok;

    assign aw_ok = !awvalid || awready;
    assign w_ok  = !wvalid || wready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= W_IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            case (state)
                W_IDLE: begin
                    if (wr_req) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        state   <= W_SEND;
                    end
                end
                W_SEND: begin
                    // address and data channels are accepted independently
                    if (awvalid && awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wvalid && wready) begin
                        wvalid <= 1'b0;
                    end
                    if (aw_ok && w_ok) begin
                        bready <= 1'b1;
                        state  <= W_RESP;
                    end
                end
                W_RESP: begin
                    if (bvalid) begin
                        bready  <= 1'b0;
                        wr_done <= 1'b1;
                        state   <= W_IDLE;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    // payload held for the whole write
    always_ff @(posedge clk) begin
        if (state == W_IDLE && wr_req) begin
            awaddr <= wr_addr;
            wdata  <= wr_data;
        end
    end

    a_awaddr_stable: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> $stable(awaddr));

    a_req_when_idle: assert property (@(posedge clk) disable iff (rst)
        wr_req |-> state == W_IDLE);

endmodule

`default_nettype wire

// ==== dma_ctrl_top.f ====
+incdir+design
design/dma_ctrl_pkg.sv
design/dma_reg_write_master.sv
design/dma_cmd_writer.sv
design/dma_phase_sequencer.sv
design/dma_ctrl_top.sv
tests/dma_engine_model.sv
tests/tb_dma_ctrl_top.sv

// ==== tests/dma_engine_model.sv ====
// behavioral DMA engine; one register write at a time, ready and interrupt delays from a fixed seed
`timescale 1ns/1ns
`default_nettype none

`include "dma_ctrl_settings.svh"

module dma_engine_model (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    delays_on,
    input  wire logic                    awvalid,
    input  wire dma_ctrl_pkg::reg_addr_t awaddr,
    input  wire logic                    wvalid,
    input  wire dma_ctrl_pkg::data_t     wdata,
    input  wire logic                    bready,
    output logic                         awready,
    output logic                         wready,
    output logic                         bvalid,
    output logic                         dma_writer_interrupt,
    output logic                         log_valid,
    output dma_ctrl_pkg::reg_addr_t      log_addr,
    output dma_ctrl_pkg::data_t          log_data
);
    import dma_ctrl_pkg::*;

    integer    seed;
    int        aw_cnt;
    int        w_cnt;
    int        intr_cnt;
    logic      aw_armed;
    logic      w_armed;
    logic      aw_got;
    logic      w_got;
    reg_addr_t addr_q;
    data_t     data_q;

    initial begin
        seed = 32'h9bb353dc;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        dma_writer_interrupt = 1'b0;
        log_valid = 1'b0;
        log_addr = '0;
        log_data = '0;
        aw_cnt = 0;
        w_cnt = 0;
        intr_cnt = 0;
        aw_armed = 1'b0;
        w_armed = 1'b0;
        aw_got = 1'b0;
        w_got = 1'b0;
        addr_q = '0;
        data_q = '0;
    end

    // all outputs change 2 ns after the edge
    always @(posedge clk) begin
        #2;
        log_valid = 1'b0;
        if (rst) begin
            awready = 1'b0;
            wready = 1'b0;
            bvalid = 1'b0;
            dma_writer_interrupt = 1'b0;
            aw_armed = 1'b0;
            w_armed = 1'b0;
            aw_got = 1'b0;
            w_got = 1'b0;
            intr_cnt = 0;
        end else begin
            // a ready raised last cycle met a stable valid at this edge
            if (awready) begin
                awready = 1'b0;
                aw_got = 1'b1;
            end else if (awvalid && !aw_got) begin
                if (!aw_armed) begin
                    aw_armed = 1'b1;
                    aw_cnt = delays_on ? ($random(seed) & 3) : 0;
                end
                if (aw_cnt == 0) begin
                    awready = 1'b1;
                    addr_q = awaddr;
                end else begin
                    aw_cnt = aw_cnt - 1;
                end
            end
            if (wready) begin
                wready = 1'b0;
                w_got = 1'b1;
            end else if (wvalid && !w_got) begin
                if (!w_armed) begin
                    w_armed = 1'b1;
                    w_cnt = delays_on ? ($random(seed) & 3) : 0;
                end
                if (w_cnt == 0) begin
                    wready = 1'b1;
                    data_q = wdata;
                end else begin
                    w_cnt = w_cnt - 1;
                end
            end
            if (bvalid) begin
                // response taken so the write is complete
                bvalid = 1'b0;
                log_valid = 1'b1;
                log_addr = addr_q;
                log_data = data_q;
                aw_got = 1'b0;
                w_got = 1'b0;
                aw_armed = 1'b0;
                w_armed = 1'b0;
                if (addr_q == `REG_CONTROL) begin
                    intr_cnt = delays_on ? ($random(seed) & 7) + 1 : 1;
                end
                if (addr_q == `REG_INTR_STATUS) begin
                    dma_writer_interrupt = 1'b0;
                end
            end else if (aw_got && w_got && bready) begin
                bvalid = 1'b1;
            end
            // transfer time before the writer interrupt
            if (intr_cnt > 0) begin
                intr_cnt = intr_cnt - 1;
                if (intr_cnt == 0) begin
                    dma_writer_interrupt = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_dma_ctrl_top.sv ====
// directed tests of the DMA controller; the first failed check ends the run
`timescale 1ns/1ns
`default_nettype none

`include "dma_ctrl_settings.svh"

module tb_dma_ctrl_top;
    import dma_ctrl_pkg::*;

    localparam int JOB_LIMIT = 20000;

    logic      clk;
    logic      rst;
    logic      start;
    cnt_t      a_ett, a_y_lim, a_y_step, a_z_lim, a_z_step;
    cnt_t      b_ett, b_y_lim, b_y_step;
    cnt_t      c_ett, c_y_lim, c_y_step, c_z_lim, c_z_step;
    addr_t     a_dram_base, b_dram_base, c_dram_base;
    logic      sauria_sync;
    logic      dma_writer_interrupt;
    logic      awready;
    logic      wready;
    logic      bvalid;
    logic      awvalid;
    reg_addr_t awaddr;
    logic      wvalid;
    data_t     wdata;
    logic      bready;
    logic      dma_sync;
    logic      busy;
    logic      done;
    logic      delays_on;
    logic      log_valid;
    reg_addr_t log_addr;
    data_t     log_data;

    // logged, expected and reference write lists
    reg_addr_t got_addr[$];
    data_t     got_data[$];
    reg_addr_t exp_addr[$];
    data_t     exp_data[$];
    reg_addr_t ref_addr[$];
    data_t     ref_data[$];
    int        exp_bring;

    dma_ctrl_top i_dut (.*);

    dma_engine_model i_eng (
        .clk(clk), .rst(rst), .delays_on(delays_on),
        .awvalid(awvalid), .awaddr(awaddr), .wvalid(wvalid), .wdata(wdata),
        .bready(bready), .awready(awready), .wready(wready), .bvalid(bvalid),
        .dma_writer_interrupt(dma_writer_interrupt),
        .log_valid(log_valid), .log_addr(log_addr), .log_data(log_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (log_valid && !rst) begin
            got_addr.push_back(log_addr);
            got_data.push_back(log_data);
        end
    end

    task automatic next_cycle;
        @(posedge clk);
        #2;
    endtask

    task automatic abort_run;
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic add_write(input reg_addr_t a, input data_t d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    // six writes per chunk with k counting chunks inside the phase
    task automatic expect_phase(input cnt_t ett, input cnt_t ylim, input cnt_t ystep,
                                input cnt_t zlim, input cnt_t zstep, input addr_t dbase,
                                input addr_t sbase, input addr_t elem, input bit send);
        int    y;
        int    z;
        addr_t k;
        addr_t dram;
        addr_t loc;
        k = '0;
        for (z = 0; z <= int'(zlim); z++) begin
            for (y = 0; y <= int'(ylim); y++) begin
                dram = dbase + (addr_t'(y) * addr_t'(ystep) + addr_t'(z) * addr_t'(zstep)) * elem;
                loc = sbase + k * addr_t'(ett) * elem;
                add_write(`REG_INTR_MASK, 32'd3);
                add_write(`REG_BTT, addr_t'(ett) * elem);
                add_write(`REG_READER_ADDR, send ? loc : dram);
                add_write(`REG_WRITER_ADDR, send ? dram : loc);
                add_write(`REG_CONTROL, 32'd3);
                add_write(`REG_INTR_STATUS, 32'd3);
                k = k + 1;
            end
        end
    endtask

    task automatic build_expected;
        exp_addr.delete();
        exp_data.delete();
        expect_phase(a_ett, a_y_lim, a_y_step, a_z_lim, a_z_step, a_dram_base,
                     `SRAMA_BASE, `A_BYTES, 1'b0);
        expect_phase(b_ett, b_y_lim, b_y_step, '0, '0, b_dram_base, `SRAMB_BASE, `B_BYTES, 1'b0);
        expect_phase(c_ett, c_y_lim, c_y_step, c_z_lim, c_z_step, c_dram_base,
                     `SRAMC_BASE, `C_BYTES, 1'b0);
        exp_bring = exp_addr.size();
        expect_phase(c_ett, c_y_lim, c_y_step, c_z_lim, c_z_step, c_dram_base,
                     `SRAMC_BASE, `C_BYTES, 1'b1);
    endtask

    task automatic set_base_config;
        a_ett = 16'd16;
        a_y_lim = '0;
        a_y_step = 16'd16;
        a_z_lim = '0;
        a_z_step = 16'd64;
        b_ett = 16'd8;
        b_y_lim = '0;
        b_y_step = 16'd8;
        c_ett = 16'd4;
        c_y_lim = '0;
        c_y_step = 16'd4;
        c_z_lim = '0;
        c_z_step = 16'd32;
        a_dram_base = 32'h8000_0000;
        b_dram_base = 32'h8010_0000;
        c_dram_base = 32'h8020_0000;
    endtask

    // one job from start to done that answers dma_sync after sync_hold cycles
    task automatic run_job(input int sync_hold, input int restart_at);
        int cycles;
        int held;
        got_addr.delete();
        got_data.delete();
        cycles = 0;
        held = 0;
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        check_value(32'(busy), 32'd1, "busy after start");
        do begin
            next_cycle();
            cycles++;
            start = (cycles == restart_at);
            if (dma_sync) begin
                check_value(got_addr.size(), exp_bring, "writes logged before or during sync");
                held++;
                sauria_sync = (held > sync_hold);
            end else begin
                sauria_sync = 1'b0;
            end
            if (cycles > JOB_LIMIT) begin
                $display("timeout at %0t: job did not signal done in %0d cycles", $time, JOB_LIMIT);
                abort_run();
            end
        end while (!done);
        sauria_sync = 1'b0;
        start = 1'b0;
        check_value(32'(busy), 32'd0, "busy falls with done");
        check_value(32'(dma_sync), 32'd0, "dma_sync at done");
        if (sync_hold > 0) begin
            check_value(held, sync_hold + 1, "cycles with dma_sync high");
        end
        next_cycle();
        check_value(32'(done), 32'd0, "done is a single pulse");
    endtask

    // start a job and reset it while the chosen outputs are high
    task automatic reset_during_job(input bit in_sync);
        int cycles;
        cycles = 0;
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        while (in_sync ? !dma_sync : !(awvalid && wvalid)) begin
            next_cycle();
            cycles++;
            if (cycles > JOB_LIMIT) begin
                $display("timeout at %0t: job did not reach the point chosen for reset", $time);
                abort_run();
            end
        end
        rst = 1'b1;
        repeat (4) next_cycle();
        rst = 1'b0;
        next_cycle();
        check_value(32'(awvalid), 32'd0, "awvalid after reset");
        check_value(32'(wvalid), 32'd0, "wvalid after reset");
        check_value(32'(dma_sync), 32'd0, "dma_sync after reset");
        check_value(32'(busy), 32'd0, "busy after reset");
    endtask

    task automatic compare_log;
        check_value(got_addr.size(), exp_addr.size(), "number of register writes");
        foreach (exp_addr[i]) begin
            check_value(32'(got_addr[i]), 32'(exp_addr[i]), $sformatf("offset of write %0d", i));
            check_value(got_data[i], exp_data[i], $sformatf("data of write %0d", i));
        end
    endtask

    task automatic single_chunk_job;
        set_base_config();
        build_expected();
        run_job(0, 0);
        compare_log();
    endtask

    task automatic grid_walk_job;
        set_base_config();
        a_y_lim = 16'd2;
        a_z_lim = 16'd1;
        a_y_step = 16'd3;
        a_z_step = 16'd10;
        build_expected();
        run_job(0, 0);
        compare_log();
        // chunk 3 is (0,1) and chunk 5 is (2,1)
        check_value(got_data[20], a_dram_base + 32'd10, "A reader address of chunk 3");
        check_value(got_data[21], `SRAMA_BASE + 32'h30, "A local address of chunk 3");
        check_value(got_data[32], a_dram_base + 32'd16, "A reader address of chunk 5");
        check_value(got_data[33], `SRAMA_BASE + 32'h50, "A local address of chunk 5");
    endtask

    task automatic held_sync_job;
        set_base_config();
        c_y_lim = 16'd1;
        build_expected();
        run_job(20, 0);
        compare_log();
    endtask

    task automatic back_pressure_job;
        set_base_config();
        a_y_lim = 16'd1;
        a_z_lim = 16'd1;
        b_y_lim = 16'd2;
        c_y_lim = 16'd1;
        c_z_lim = 16'd1;
        build_expected();
        delays_on = 1'b0;
        run_job(0, 0);
        compare_log();
        ref_addr = got_addr;
        ref_data = got_data;
        delays_on = 1'b1;
        run_job(3, 0);
        delays_on = 1'b0;
        check_value(got_addr.size(), ref_addr.size(), "write count with delays");
        foreach (ref_addr[i]) begin
            check_value(32'(got_addr[i]), 32'(ref_addr[i]), $sformatf("delayed offset %0d", i));
            check_value(got_data[i], ref_data[i], $sformatf("delayed data %0d", i));
        end
    endtask

    task automatic ignored_start_job;
        set_base_config();
        b_y_lim = 16'd1;
        build_expected();
        run_job(0, 15);
        compare_log();
        // a second job would show up here
        repeat (30) begin
            next_cycle();
            check_value(32'(busy), 32'd0, "busy after the only job");
        end
        check_value(got_addr.size(), exp_addr.size(), "writes after the only job");
    endtask

    task automatic reset_mid_job;
        set_base_config();
        a_y_lim = 16'd3;
        build_expected();
        reset_during_job(1'b0);
        reset_during_job(1'b1);
        run_job(0, 0);
        compare_log();
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        sauria_sync = 1'b0;
        delays_on = 1'b0;
        set_base_config();
        repeat (4) next_cycle();
        rst = 1'b0;
        next_cycle();
        single_chunk_job();
        grid_walk_job();
        held_sync_job();
        back_pressure_job();
        ignored_start_job();
        reset_mid_job();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire
